// File: hw/commit_stage.sv
`include "rob_defs.svh"
`default_nettype none

module commit_stage import rob_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire rob_entry_t                retire,
    output logic                           retire_allow,
    input  wire logic                      out_credit,
    input  wire logic [`REG_ADDR_LEN-1:0]  rf_raddr,
    output logic [`XLEN-1:0]               rf_rdata,
    output logic                           commit_valid,
    output commit_t                        commit_out,
    output logic                           flush,
    output logic [`XLEN-1:0]               redirect_pc
);

    localparam int CR_W = $clog2(`OUT_CREDITS + 1);

    logic [`XLEN-1:0] rf [`NUM_REGS];
    logic [CR_W-1:0]  credit_cnt;
    logic             redirect;

    assign rf_rdata     = rf[rf_raddr];
    assign retire_allow = (credit_cnt != '0);
    assign redirect     = retire.valid && retire.mispredict;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt   <= CR_W'(`OUT_CREDITS);
            commit_valid <= 1'b0;
            commit_out   <= '0;
            flush        <= 1'b0;
            redirect_pc  <= '0;
            for (int i = 0; i < `NUM_REGS; i++) rf[i] <= '0;
        end else begin
            // Credit is spent at retire, one cycle ahead of commit_valid.
            credit_cnt   <= credit_cnt + CR_W'(out_credit) - CR_W'(retire.valid);
            commit_valid <= retire.valid;
            flush        <= redirect;
            if (retire.valid) begin
                commit_out.seq   <= retire.seq;
                commit_out.dst   <= retire.dst;
                commit_out.data  <= retire.data;
                commit_out.flush <= retire.mispredict;
                if (!retire.is_branch) rf[retire.dst] <= retire.data;
            end
            if (redirect) redirect_pc <= retire.data;  // Branch result is the target.
        end
    end

endmodule

`default_nettype wire

// File: hw/dispatch_stage.sv
`include "rob_defs.svh"
`default_nettype none

module dispatch_stage import rob_pkg::*; (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic                     flush,
    input  wire logic                     iq_valid,
    input  wire instr_t                   iq_head,
    output logic                          iq_pop,
    input  wire logic                     rob_full,
    output logic                          alloc,
    output rob_entry_t                    alloc_entry,
    input  wire logic [`ROB_TAG_LEN-1:0]  alloc_tag,
    output logic [`ROB_TAG_LEN-1:0]       search_tag,
    input  wire logic                     search_ready,
    input  wire logic [`XLEN-1:0]         search_data,
    output logic [`REG_ADDR_LEN-1:0]      rf_raddr,
    input  wire logic [`XLEN-1:0]         rf_rdata,
    input  wire logic                     slot_free,
    output logic                          issue_valid,
    output logic [`XLEN-1:0]              issue_operand,
    output logic [`XLEN-1:0]              issue_imm,
    output logic [1:0]                    issue_lat,
    output logic [`ROB_TAG_LEN-1:0]       issue_tag,
    input  wire rob_entry_t               retire,
    input  wire logic [`ROB_TAG_LEN-1:0]  retire_tag
);

    logic [`NUM_REGS-1:0]    rt_busy;
    logic [`ROB_TAG_LEN-1:0] rt_tag [`NUM_REGS];
    logic                    src_busy;
    logic                    src_ok;
    logic                    rename_dst;
    logic                    retire_clear;

    assign src_busy   = rt_busy[iq_head.src];
    assign search_tag = rt_tag[iq_head.src];
    assign rf_raddr   = iq_head.src;
    assign src_ok     = !src_busy || search_ready;   // No bypass from the bus.

    assign iq_pop      = iq_valid && !flush && !rob_full && slot_free && src_ok;
    assign alloc       = iq_pop;
    assign issue_valid = iq_pop;
    assign rename_dst  = alloc && !iq_head.is_branch;  // Branches write no register.

    assign issue_operand = src_busy ? search_data : rf_rdata;
    assign issue_imm     = iq_head.imm;
    assign issue_lat     = iq_head.lat;
    assign issue_tag     = alloc_tag;

    always_comb begin
        alloc_entry            = '0;
        alloc_entry.valid      = 1'b1;
        alloc_entry.is_branch  = iq_head.is_branch;
        alloc_entry.dst        = iq_head.dst;
        alloc_entry.seq        = iq_head.seq;
    end

    // Only the youngest producer of a register may clear its mapping.
    assign retire_clear = retire.valid && !retire.is_branch && rt_busy[retire.dst]
                          && (rt_tag[retire.dst] == retire_tag);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rt_busy <= '0;
        end else if (flush) begin
            rt_busy <= '0;
        end else begin
            if (retire_clear) rt_busy[retire.dst] <= 1'b0;
            if (rename_dst) rt_busy[iq_head.dst] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rename_dst) rt_tag[iq_head.dst] <= alloc_tag;
    end

endmodule

`default_nettype wire

// File: hw/exec_pipe.sv
`include "rob_defs.svh"
`default_nettype none

module exec_pipe import rob_pkg::*; (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic                     flush,
    input  wire logic                     issue_valid,
    input  wire logic [`XLEN-1:0]         issue_operand,
    input  wire logic [`XLEN-1:0]         issue_imm,
    input  wire logic [1:0]               issue_lat,
    input  wire logic [`ROB_TAG_LEN-1:0]  issue_tag,
    input  wire logic                     issue_mispredict,
    output logic                          slot_free,
    output cdb_t                          cdb
);

    logic [`EXEC_SLOTS-1:0]  busy;
    logic [`EXEC_SLOTS-1:0]  done;
    logic [`EXEC_SLOTS-1:0]  load_oh;
    logic [`EXEC_SLOTS-1:0]  win_oh;
    logic [2:0]              cnt     [`EXEC_SLOTS];
    logic [`ROB_TAG_LEN-1:0] tag     [`EXEC_SLOTS];
    logic [`XLEN-1:0]        operand [`EXEC_SLOTS];
    logic [`XLEN-1:0]        imm     [`EXEC_SLOTS];
    logic [`XLEN-1:0]        result  [`EXEC_SLOTS];
    logic                    misp    [`EXEC_SLOTS];

    assign slot_free = !(&busy);

    // Lowest idle slot takes the issue, lowest finished slot takes the bus.
    always_comb begin
        load_oh = '0;
        win_oh  = '0;
        cdb     = '0;
        for (int i = 0; i < `EXEC_SLOTS; i++) begin
            if (!busy[i] && load_oh == '0) load_oh[i] = issue_valid;
            if (done[i] && win_oh == '0) begin
                win_oh[i]      = 1'b1;
                cdb.valid      = 1'b1;
                cdb.tag        = tag[i];
                cdb.data       = result[i];
                cdb.mispredict = misp[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
            done <= '0;
            for (int i = 0; i < `EXEC_SLOTS; i++) cnt[i] <= '0;
        end else if (flush) begin
            busy <= '0;
            done <= '0;
        end else begin
            for (int i = 0; i < `EXEC_SLOTS; i++) begin
                if (win_oh[i]) begin
                    busy[i] <= 1'b0;
                    done[i] <= 1'b0;
                end else if (load_oh[i]) begin
                    busy[i] <= 1'b1;
                    cnt[i]  <= {1'b0, issue_lat} + 3'd1;
                end else if (busy[i] && !done[i]) begin
                    cnt[i] <= cnt[i] - 3'd1;
                    if (cnt[i] == 3'd1) done[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `EXEC_SLOTS; i++) begin
            if (load_oh[i]) begin
                tag[i]     <= issue_tag;
                operand[i] <= issue_operand;
                imm[i]     <= issue_imm;
                misp[i]    <= issue_mispredict;
            end
            if (busy[i] && !done[i] && cnt[i] == 3'd1) result[i] <= operand[i] + imm[i];
        end
    end

endmodule

`default_nettype wire

// File: hw/instr_queue.sv
`include "rob_defs.svh"
`default_nettype none

module instr_queue import rob_pkg::*; (
    input  wire logic   clk,
    input  wire logic   arst_n,
    input  wire logic   flush,
    input  wire logic   in_valid,
    input  wire instr_t in_instr,
    input  wire logic   iq_pop,
    output logic        iq_valid,
    output instr_t      iq_head,
    output logic        in_credit
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);
    localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

    instr_t             mem [`IQ_DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   pending;       // Credits still owed to the producer.
    logic [CNT_W-1:0]   pending_add;

    assign iq_valid  = (count != '0);
    assign iq_head   = mem[rd_ptr];
    assign in_credit = (pending != '0);

    // A flush owes one credit per discarded entry, including a beat arriving now.
    assign pending_add = flush ? count + CNT_W'(in_valid) : CNT_W'(iq_pop);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count   <= '0;
            pending <= '0;
        end else begin
            pending <= pending - CNT_W'(in_credit) + pending_add;
            if (flush) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
                count  <= '0;
            end else begin
                if (in_valid) wr_ptr <= wr_ptr + 1'b1;
                if (iq_pop) rd_ptr <= rd_ptr + 1'b1;
                count <= count + CNT_W'(in_valid) - CNT_W'(iq_pop);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && !flush) mem[wr_ptr] <= in_instr;
    end

endmodule

`default_nettype wire

// File: hw/ooo_core_top.sv
`include "rob_defs.svh"
`default_nettype none

module ooo_core_top import rob_pkg::*; (
    input  wire logic          clk,
    input  wire logic          arst_n,
    input  wire logic          in_valid,
    input  wire instr_t        in_instr,
    output logic               in_credit,
    output logic               commit_valid,
    output commit_t            commit_out,
    input  wire logic          out_credit,
    output logic               flush,
    output logic [`XLEN-1:0]   redirect_pc
);

    logic                     iq_valid;
    instr_t                   iq_head;
    logic                     iq_pop;
    logic                     rob_full;
    logic                     alloc;
    rob_entry_t               alloc_entry;
    logic [`ROB_TAG_LEN-1:0]  alloc_tag;
    logic [`ROB_TAG_LEN-1:0]  search_tag;
    logic                     search_ready;
    logic [`XLEN-1:0]         search_data;
    logic [`REG_ADDR_LEN-1:0] rf_raddr;
    logic [`XLEN-1:0]         rf_rdata;
    logic                     slot_free;
    logic                     issue_valid;
    logic [`XLEN-1:0]         issue_operand;
    logic [`XLEN-1:0]         issue_imm;
    logic [1:0]               issue_lat;
    logic [`ROB_TAG_LEN-1:0]  issue_tag;
    logic                     issue_mispredict;
    cdb_t                     cdb;
    rob_entry_t               retire;
    logic [`ROB_TAG_LEN-1:0]  retire_tag;
    logic                     retire_allow;

    // Only a branch can carry a mispredict to the bus.
    assign issue_mispredict = iq_head.is_branch && iq_head.mispredict;

    instr_queue u_iq (
        .clk, .arst_n, .flush,
        .in_valid, .in_instr, .iq_pop, .iq_valid, .iq_head, .in_credit
    );

    dispatch_stage u_dispatch (
        .clk, .arst_n, .flush,
        .iq_valid, .iq_head, .iq_pop,
        .rob_full, .alloc, .alloc_entry, .alloc_tag,
        .search_tag, .search_ready, .search_data,
        .rf_raddr, .rf_rdata, .slot_free,
        .issue_valid, .issue_operand, .issue_imm, .issue_lat, .issue_tag,
        .retire, .retire_tag
    );

    exec_pipe u_exec (
        .clk, .arst_n, .flush,
        .issue_valid, .issue_operand, .issue_imm, .issue_lat, .issue_tag,
        .issue_mispredict, .slot_free, .cdb
    );

    reorder_buffer u_rob (
        .clk, .arst_n, .flush,
        .alloc, .alloc_entry, .alloc_tag, .rob_full, .cdb,
        .search_tag, .search_ready, .search_data,
        .retire_allow, .retire, .retire_tag
    );

    commit_stage u_commit (
        .clk, .arst_n, .retire, .retire_allow, .out_credit,
        .rf_raddr, .rf_rdata, .commit_valid, .commit_out, .flush, .redirect_pc
    );

endmodule

`default_nettype wire

// File: hw/reorder_buffer.sv
`include "rob_defs.svh"
`default_nettype none

module reorder_buffer import rob_pkg::*; (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic                     flush,
    input  wire logic                     alloc,
    input  wire rob_entry_t               alloc_entry,
    output logic [`ROB_TAG_LEN-1:0]       alloc_tag,
    output logic                          rob_full,
    input  wire cdb_t                     cdb,
    input  wire logic [`ROB_TAG_LEN-1:0]  search_tag,
    output logic                          search_ready,
    output logic [`XLEN-1:0]              search_data,
    input  wire logic                     retire_allow,
    output rob_entry_t                    retire,
    output logic [`ROB_TAG_LEN-1:0]       retire_tag
);

    localparam int CNT_W = `ROB_TAG_LEN + 1;

    rob_entry_t              entries [`ROB_SIZE];
    logic [`ROB_TAG_LEN-1:0] head;
    logic [`ROB_TAG_LEN-1:0] tail;
    logic [CNT_W-1:0]        count;
    logic                    do_retire;
    rob_entry_t              head_entry;

    assign head_entry = entries[head];
    assign alloc_tag  = tail;
    assign rob_full   = (count == CNT_W'(`ROB_SIZE));
    assign retire_tag = head;

    // Nothing retires in the cycle the flush is seen.
    assign do_retire = head_entry.valid && head_entry.ready && retire_allow && !flush;

    always_comb begin
        retire       = head_entry;
        retire.valid = do_retire;
    end

    assign search_ready = entries[search_tag].ready;
    assign search_data  = entries[search_tag].data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc) tail <= tail + 1'b1;
            if (do_retire) head <= head + 1'b1;
            count <= count + CNT_W'(alloc) - CNT_W'(do_retire);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `ROB_SIZE; i++) entries[i] <= '0;
        end else if (flush) begin
            for (int i = 0; i < `ROB_SIZE; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].ready <= 1'b0;
            end
        end else begin
            if (cdb.valid) begin
                entries[cdb.tag].ready      <= 1'b1;
                entries[cdb.tag].data       <= cdb.data;
                entries[cdb.tag].mispredict <= cdb.mispredict;
            end
            if (do_retire) begin
                entries[head].valid <= 1'b0;
                entries[head].ready <= 1'b0;
            end
            if (alloc) begin
                entries[tail]            <= alloc_entry;
                entries[tail].valid      <= 1'b1;
                entries[tail].ready      <= 1'b0;
                entries[tail].mispredict <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/rob_defs.svh
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

`default_nettype none

`define XLEN          32
`define REG_ADDR_LEN  3
`define NUM_REGS      8
`define ROB_SIZE      8
`define ROB_TAG_LEN   3
`define IQ_DEPTH      4   // Also the producer's initial credits.
`define OUT_CREDITS   2
`define EXEC_SLOTS    3
`define SEQ_LEN       8

`default_nettype wire

`endif

// File: hw/rob_pkg.sv
`include "rob_defs.svh"
`default_nettype none

package rob_pkg;

    typedef struct packed {
        logic [`SEQ_LEN-1:0]      seq;
        logic [`REG_ADDR_LEN-1:0] dst;
        logic [`REG_ADDR_LEN-1:0] src;
        logic [`XLEN-1:0]         imm;
        logic [1:0]               lat;         // Encodes 1 to 4 cycles.
        logic                     is_branch;
        logic                     mispredict;
    } instr_t;

    typedef struct packed {
        logic                    valid;
        logic [`ROB_TAG_LEN-1:0] tag;
        logic [`XLEN-1:0]        data;
        logic                    mispredict;
    } cdb_t;

    typedef struct packed {
        logic                     valid;
        logic                     ready;
        logic                     mispredict;
        logic                     is_branch;
        logic [`REG_ADDR_LEN-1:0] dst;
        logic [`SEQ_LEN-1:0]      seq;
        logic [`XLEN-1:0]         data;
    } rob_entry_t;

    typedef struct packed {
        logic [`SEQ_LEN-1:0]      seq;
        logic [`REG_ADDR_LEN-1:0] dst;
        logic [`XLEN-1:0]         data;
        logic                     flush;
    } commit_t;

endpackage

`default_nettype wire

// File: list.f
+incdir+hw
hw/rob_pkg.sv
hw/instr_queue.sv
hw/dispatch_stage.sv
hw/exec_pipe.sv
hw/reorder_buffer.sv
hw/commit_stage.sv
hw/ooo_core_top.sv
testbench/ooo_core_assert.sv
testbench/ooo_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it into sim.log and scans the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module ooo_core_tb -f list.f -o sim_tb \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation stopped early, see sim.log"; exit 1; }
echo "Simulation passed"

// File: testbench/ooo_core_assert.sv
`include "rob_defs.svh"
`default_nettype none

module ooo_core_assert (
    input wire logic                                 clk,
    input wire logic                                 arst_n,
    input wire logic                                 in_valid,
    input wire logic                                 in_credit,
    input wire logic                                 commit_valid,
    input wire logic                                 out_credit,
    input wire logic                                 flush,
    input wire logic [$clog2(`IQ_DEPTH + 1)-1:0]     iq_count,
    input wire logic [$clog2(`OUT_CREDITS + 1)-1:0]  out_cnt
);
    timeunit 1ns;
    timeprecision 100ps;

    int in_avail;    // Producer credits held.
    int out_avail;   // Output credits counted at commit_valid.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_avail  <= `IQ_DEPTH;
            out_avail <= `OUT_CREDITS;
        end else begin
            in_avail  <= in_avail - int'(in_valid) + int'(in_credit);
            out_avail <= out_avail - int'(commit_valid) + int'(out_credit);
        end
    end

    a_flush_with_commit: assert property (@(posedge clk) disable iff (!arst_n)
        flush |-> commit_valid) else $error("flush raised without commit_valid");

    a_quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !commit_valid && !in_credit) else $error("output active during reset");

    a_queue_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> iq_count < `IQ_DEPTH)
        else $error("queue overflow, beat arrived while the queue was full");

    a_in_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
        in_avail <= `IQ_DEPTH) else $error("more input credits returned than slots");

    a_out_credit_held: assert property (@(posedge clk) disable iff (!arst_n)
        commit_valid |-> out_avail > 0) else $error("commit_valid without an output credit");

    a_out_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
        out_cnt <= `OUT_CREDITS) else $error("output credits exceed the initial count");

endmodule

bind ooo_core_top ooo_core_assert u_assert (
    .*,
    .iq_count(u_iq.count),
    .out_cnt(u_commit.credit_cnt)
);

`default_nettype wire

// File: testbench/ooo_core_tb.sv
`include "rob_defs.svh"
`default_nettype none

module ooo_core_tb import rob_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int M_RANDOM  = 0;
    localparam int M_BACKP   = 1;
    localparam int M_FLUSH   = 2;
    localparam int M_CHAIN   = 3;
    localparam int LIMIT     = 4000;

    logic                     clk = 1'b0;
    logic                     arst_n;
    logic                     in_valid;
    instr_t                   in_instr;
    logic                     in_credit;
    logic                     commit_valid;
    commit_t                  commit_out;
    logic                     out_credit = 1'b0;
    logic                     flush;
    logic [`XLEN-1:0]         redirect_pc;

    logic [15:0]              lfsr_q = 16'd63;
    logic [`XLEN-1:0]         model_rf [`NUM_REGS];
    commit_t                  expq [$];
    string                    test_name = "reset";
    int                       credits = `IQ_DEPTH;
    int                       owed = 0;
    int                       cyc = 0;
    int                       value_errs = 0;
    int                       extra_errs = 0;
    int                       timeouts = 0;
    logic                     withhold = 1'b0;
    logic                     misp_pending = 1'b0;  // Younger beats get no record.
    logic                     flush_seen = 1'b0;
    logic [7:0]               seq_q = '0;
    logic [`REG_ADDR_LEN-1:0] last_dst = '0;

    ooo_core_top dut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic finish_run();
        $display("Errors: value %0d, unexpected %0d, timeout %0d",
                 value_errs, extra_errs, timeouts);
        if (value_errs + extra_errs + timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout in test %s: %s", test_name, what);
        finish_run();
    endtask

    // Moves to the drive point of the next cycle and collects input credit.
    task automatic step_cycle();
        if (flush_seen) misp_pending = 1'b0;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        if (in_credit) credits++;
        flush_seen = flush;
    endtask

    task automatic send_instr(input int mode);
        instr_t  ins;
        commit_t exp;
        ins.seq        = seq_q;
        ins.dst        = 3'(rand_bits(3));
        ins.src        = (mode == M_CHAIN) ? last_dst : 3'(rand_bits(3));
        ins.imm        = rand_bits(16);
        ins.lat        = (mode == M_CHAIN) ? 2'd3 : 2'(rand_bits(2));
        ins.is_branch  = (mode != M_CHAIN) && (2'(rand_bits(2)) == 2'd0);
        ins.mispredict = (mode == M_FLUSH) && ins.is_branch && rand_bits(1) != 0;
        exp.seq        = ins.seq;
        exp.dst        = ins.dst;
        exp.data       = model_rf[ins.src] + ins.imm;
        exp.flush      = ins.is_branch && ins.mispredict;
        if (!misp_pending) begin
            expq.push_back(exp);
            if (!ins.is_branch) model_rf[ins.dst] = exp.data;
            if (exp.flush) misp_pending = 1'b1;
        end
        last_dst = ins.dst;
        seq_q++;
        in_instr = ins;
        in_valid = 1'b1;
        credits--;
    endtask

    task automatic run_stream(input string name, input int mode, input int n);
        int sent;
        int idle;
        test_name = name;
        withhold  = (mode == M_BACKP);
        sent = 0;
        idle = 0;
        while (sent < n) begin
            step_cycle();
            if (credits > 0 && 2'(rand_bits(2)) != 2'd0) begin
                send_instr(mode);
                sent++;
                idle = 0;
            end else begin
                idle++;
                if (idle > LIMIT) report_timeout("no input credit came back");
            end
        end
        idle = 0;
        while (expq.size() != 0 || credits != `IQ_DEPTH || misp_pending) begin
            step_cycle();
            idle++;
            if (idle > LIMIT) report_timeout("stream did not drain or credits did not return");
        end
    endtask

    task automatic check_commit();
        commit_t exp;
        assert (expq.size() != 0) else begin
            extra_errs++;
            $display("Commit of seq %0d in test %s came with nothing expected",
                     commit_out.seq, test_name);
        end
        if (expq.size() != 0) begin
            exp = expq.pop_front();
            assert (commit_out == exp) else begin
                value_errs++;
                $display("ERROR %s: commit expected %h actual %h", test_name, exp, commit_out);
            end
            assert (flush == exp.flush && (!exp.flush || redirect_pc == exp.data)) else begin
                value_errs++;
                $display("ERROR %s: flush/redirect expected %b/%h actual %b/%h",
                         test_name, exp.flush, exp.data, flush, redirect_pc);
            end
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && commit_valid) begin
            check_commit();
            owed++;
        end
    end

    // Consumer returns credits, only a few cycles in 32 while withholding.
    always @(posedge clk) begin
        #1;
        out_credit = 1'b0;
        if (owed > 0 && (!withhold || cyc % 32 < 3)) begin
            out_credit = 1'b1;
            owed--;
        end
        cyc++;
    end

    initial begin
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        for (int i = 0; i < `NUM_REGS; i++) model_rf[i] = '0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        run_stream("in_order", M_RANDOM, 40);
        run_stream("back_pressure", M_BACKP, 40);
        run_stream("mispredict", M_FLUSH, 48);
        run_stream("dep_chain", M_CHAIN, 24);
        finish_run();
    end

endmodule

`default_nettype wire
